/* src.f */
verilog/mrd_pkg.sv
verilog/mrd_sink_stage.sv
verilog/mrd_bin_lane.sv
verilog/mrd_bfp_source.sv
verilog/mrd_dft4_top.sv
tests/mrd_dft4_tb.sv

/* tests/mrd_dft4_tb.sv */
// streaming dft4 testbench

`timescale 1ns/1ps

module mrd_dft4_tb;

	import mrd_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int TIMEOUT = 200;
	localparam int SEED = 32'h49de;
	localparam int FULL_POS = 2**(DATA_W-1) - 1;
	localparam int FULL_NEG = -(2**(DATA_W-1));

	typedef cplx_t [LANES-1:0] beat_data_t;

	logic clk;
	logic reset;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	beat_data_t sink_data;
	logic inverse;
	logic source_ready;
	logic source_valid;
	source_beat_t source_beat;

	integer seed;
	integer ready_seed;
	logic ready_random;
	string test_name;

	// scoreboard and frame model
	source_beat_t exp_q [$];
	source_beat_t ref_beat;
	source_beat_t want;
	logic model_in_frame;
	logic model_inv;
	time accept_time;
	time out_time;
	int popped_count;
	int stray_base;

	mrd_dft4_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.sink_data    (sink_data),
		.inverse      (inverse),
		.source_ready (source_ready),
		.source_valid (source_valid),
		.source_beat  (source_beat)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		stop_with_error($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
			test_name, what, expected, actual));
	endtask

	// X[k] = sum of x[n] * w^(nk) with w = -j forward and +j inverse
	function automatic source_beat_t dft4_ref(input beat_data_t samp, input logic inv);
		int acc_re [LANES];
		int acc_im [LANES];
		int a;
		int b;
		int c;
		int s;
		int m;
		int shift;
		logic found;
		logic ok;
		source_beat_t r;
		r = '0;
		for (int k = 0; k < LANES; k++)
		begin
			acc_re[k] = 0;
			acc_im[k] = 0;
			for (int n = 0; n < LANES; n++)
			begin
				// cos and sin of the forward power (-j)^(nk)
				m = (n * k) % LANES;
				c = (m == 0) ? 1 : ((m == 2) ? -1 : 0);
				s = (m == 1) ? -1 : ((m == 3) ? 1 : 0);
				if (inv)
					s = -s;
				a = $signed(samp[n].re);
				b = $signed(samp[n].im);
				acc_re[k] += a * c - b * s;
				acc_im[k] += a * s + b * c;
			end
		end
		// smallest shift that brings every part into signed DATA_W
		shift = 2;
		found = 1'b0;
		for (int t = 0; t < 3; t++)
		begin
			ok = 1'b1;
			for (int k = 0; k < LANES; k++)
			begin
				if ((acc_re[k] >>> t) > FULL_POS || (acc_re[k] >>> t) < FULL_NEG)
					ok = 1'b0;
				if ((acc_im[k] >>> t) > FULL_POS || (acc_im[k] >>> t) < FULL_NEG)
					ok = 1'b0;
			end
			if (ok && !found)
			begin
				shift = t;
				found = 1'b1;
			end
		end
		for (int k = 0; k < LANES; k++)
		begin
			r.bin[k].re = DATA_W'(acc_re[k] >>> shift);
			r.bin[k].im = DATA_W'(acc_im[k] >>> shift);
		end
		r.exp = EXP_W'(shift);
		return r;
	endfunction

	function automatic beat_data_t rand_beat(input int bits);
		beat_data_t d;
		int v;
		for (int n = 0; n < LANES; n++)
		begin
			v = $random(seed);
			d[n].re = DATA_W'(v >>> (32 - bits));
			v = $random(seed);
			d[n].im = DATA_W'(v >>> (32 - bits));
		end
		return d;
	endfunction

	function automatic beat_data_t fill_beat(input int re, input int im);
		beat_data_t d;
		for (int n = 0; n < LANES; n++)
		begin
			d[n].re = DATA_W'(re);
			d[n].im = DATA_W'(im);
		end
		return d;
	endfunction

	// hold the beat until the dut takes it
	task automatic send_beat(input logic sop, input logic eop, input logic inv,
			input beat_data_t data);
		int count;
		count = 0;
		@(negedge clk);
		sink_valid = 1'b1;
		sink_sop = sop;
		sink_eop = eop;
		inverse = inv;
		sink_data = data;
		@(posedge clk);
		while (!sink_ready)
		begin
			count++;
			if (count > TIMEOUT)
				stop_with_error("sink_ready stayed low and the beat was never accepted");
			@(posedge clk);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			sink_valid = 1'b0;
			sink_sop = 1'b0;
			sink_eop = 1'b0;
		end
	endtask

	// odd beats flip the inverse input when toggle is set
	task automatic send_frame(input int beats, input logic inv, input int bits,
			input logic toggle);
		logic beat_inv;
		for (int i = 0; i < beats; i++)
		begin
			beat_inv = toggle ? inv ^ i[0] : inv;
			send_beat(i == 0, i == beats - 1, beat_inv, rand_beat(bits));
		end
	endtask

	task automatic send_checked(input logic sop, input logic eop, input beat_data_t data,
			input int want_exp);
		source_beat_t r;
		r = dft4_ref(data, 1'b0);
		assert (r.exp == want_exp) else report_mismatch("reference exp", want_exp, r.exp);
		send_beat(sop, eop, 1'b0, data);
	endtask

	task automatic wait_drain();
		int count;
		count = 0;
		while (exp_q.size() != 0)
		begin
			@(negedge clk);
			count++;
			if (count > TIMEOUT)
				stop_with_error("expected output beats did not arrive in time");
		end
	endtask

	// random stalls on the source side
	always @(negedge clk)
	begin
		if (ready_random)
			source_ready = ($random(ready_seed) & 3) != 0;
		else
			source_ready = 1'b1;
	end

	// frame model on every sink transfer
	always @(posedge clk)
	begin
		if (!reset && sink_valid && sink_ready)
		begin
			accept_time = $time;
			if (sink_sop || model_in_frame)
			begin
				if (sink_sop)
					model_inv = inverse;
				ref_beat = dft4_ref(sink_data, model_inv);
				ref_beat.sop = sink_sop;
				ref_beat.eop = sink_eop;
				exp_q.push_back(ref_beat);
				model_in_frame = !sink_eop;
			end
		end
	end

	// compare every source transfer with the oldest expected beat
	always @(posedge clk)
	begin
		if (!reset && source_valid && source_ready)
		begin
			assert (exp_q.size() != 0)
			else
				stop_with_error("an output beat arrived that no input beat accounts for");
			if (exp_q.size() != 0)
			begin
				want = exp_q.pop_front();
				popped_count++;
				out_time = $time;
				for (int b = 0; b < LANES; b++)
				begin
					assert (source_beat.bin[b] == want.bin[b])
					else
						report_mismatch($sformatf("bin %0d", b), want.bin[b], source_beat.bin[b]);
				end
				assert (source_beat.sop == want.sop)
				else
					report_mismatch("sop", want.sop, source_beat.sop);
				assert (source_beat.eop == want.eop)
				else
					report_mismatch("eop", want.eop, source_beat.eop);
				assert (source_beat.exp == want.exp)
				else
					report_mismatch("exp", want.exp, source_beat.exp);
			end
		end
	end

	initial
	begin
		beat_data_t mixed;
		seed = SEED;
		ready_seed = SEED + 1;
		ready_random = 1'b0;
		reset = 1'b1;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		sink_data = '0;
		inverse = 1'b0;
		source_ready = 1'b1;
		model_in_frame = 1'b0;
		model_inv = 1'b0;
		accept_time = 0;
		out_time = 0;
		popped_count = 0;
		stray_base = 0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "reset_and_latency";
		assert (source_valid == 1'b0) else report_mismatch("source_valid", 0, source_valid);
		assert (sink_ready == 1'b1) else report_mismatch("sink_ready", 1, sink_ready);
		send_frame(1, 1'b0, DATA_W, 1'b0);
		idle_cycles(1);
		wait_drain();
		assert (out_time - accept_time == 3 * CLK_PERIOD)
		else
			report_mismatch("latency", 3, (out_time - accept_time) / CLK_PERIOD);

		test_name = "forward_frames";
		repeat (4) send_frame(5, 1'b0, DATA_W, 1'b0);
		idle_cycles(2);
		wait_drain();

		// inverse input flips on odd beats while the frame keeps its sop value
		test_name = "inverse_frames";
		repeat (3) send_frame(4, 1'b1, DATA_W, 1'b1);
		send_frame(4, 1'b0, DATA_W, 1'b1);
		idle_cycles(2);
		wait_drain();

		test_name = "block_exponent";
		mixed = '0;
		mixed[0].re = DATA_W'(FULL_POS);
		mixed[0].im = DATA_W'(-FULL_POS);
		mixed[1] = mixed[0];
		send_checked(1'b1, 1'b0, fill_beat(FULL_POS, FULL_POS), 2);
		send_checked(1'b0, 1'b0, fill_beat(FULL_NEG, FULL_NEG), 2);
		send_checked(1'b0, 1'b0, rand_beat(14), 0);
		send_checked(1'b0, 1'b1, mixed, 1);
		idle_cycles(2);
		wait_drain();

		test_name = "backpressure";
		ready_random = 1'b1;
		repeat (6) send_frame(3, $random(seed), DATA_W, 1'b1);
		idle_cycles(3);
		repeat (3) send_frame(2, 1'b0, DATA_W, 1'b0);
		idle_cycles(2);
		wait_drain();
		ready_random = 1'b0;

		// only the two beats of the real frame may come out
		test_name = "stray_beats";
		stray_base = popped_count;
		send_beat(1'b0, 1'b0, 1'b0, rand_beat(DATA_W));
		send_beat(1'b0, 1'b1, 1'b1, rand_beat(DATA_W));
		send_frame(2, 1'b0, DATA_W, 1'b0);
		send_beat(1'b0, 1'b0, 1'b0, rand_beat(DATA_W));
		idle_cycles(10);
		wait_drain();
		assert (popped_count - stray_base == 2)
		else
			report_mismatch("beats received", 2, popped_count - stray_base);

		$display("Everything OK");
		$finish;
	end

endmodule

/* verilog/mrd_bfp_source.sv */
// dft4 block exponent source stage

`timescale 1ns/1ps

module mrd_bfp_source (
	input  logic clk,
	input  logic reset,
	input  logic l_valid,
	input  mrd_pkg::lane_beat_t l_beat,
	input  logic source_ready,
	output logic advance,
	output logic source_valid,
	output mrd_pkg::source_beat_t source_beat
);

	import mrd_pkg::*;

	// per-shift fit flags over all bins
	logic fit_s0;
	logic fit_s1;

	// chosen shift, 0 to 2
	logic [1:0] shift;

	// next register contents
	source_beat_t nxt;

	// shifted parts before truncation
	logic signed [WIDE_W-1:0] sh_re;
	logic signed [WIDE_W-1:0] sh_im;

	// true when v >>> s still fits a signed DATA_W word
	function automatic logic fits(input logic signed [WIDE_W-1:0] v, input int s);
		logic signed [WIDE_W-1:0] sh;
		sh = v >>> s;
		return sh[WIDE_W-1:DATA_W-1] == {(WIDE_W-DATA_W+1){sh[WIDE_W-1]}};
	endfunction

	// a single stall point for the whole pipeline
	assign advance = ~source_valid | source_ready;

	// find the smallest shift that every part survives
	always_comb
	begin
		fit_s0 = 1'b1;
		fit_s1 = 1'b1;
		for (int b = 0; b < LANES; b++)
		begin
			fit_s0 = fit_s0 & fits(l_beat.bin[b].re, 0) & fits(l_beat.bin[b].im, 0);
			fit_s1 = fit_s1 & fits(l_beat.bin[b].re, 1) & fits(l_beat.bin[b].im, 1);
		end
		// two bits of growth always fit after a shift of 2
		if (fit_s0)
			shift = 2'd0;
		else if (fit_s1)
			shift = 2'd1;
		else
			shift = 2'd2;
	end

	// apply the shift and drop the growth bits
	always_comb
	begin
		sh_re = '0;
		sh_im = '0;
		nxt = '0;
		for (int b = 0; b < LANES; b++)
		begin
			sh_re = l_beat.bin[b].re >>> shift;
			sh_im = l_beat.bin[b].im >>> shift;
			nxt.bin[b].re = sh_re[DATA_W-1:0];
			nxt.bin[b].im = sh_im[DATA_W-1:0];
		end
		nxt.sop = l_beat.sop;
		nxt.eop = l_beat.eop;
		nxt.exp = EXP_W'(shift);
	end

	// output valid, held while the sink side stalls
	always_ff @(posedge clk)
	begin
		if (reset)
			source_valid <= 1'b0;
		else if (advance)
			source_valid <= l_valid;
	end

	// output payload
	always_ff @(posedge clk)
	begin
		if (advance)
			source_beat <= nxt;
	end

endmodule

/* verilog/mrd_bin_lane.sv */
// dft4 output bin lane

`timescale 1ns/1ps

module mrd_bin_lane #(
	parameter int BIN = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic advance,
	input  logic s_valid,
	input  mrd_pkg::sink_beat_t s_beat,
	output logic l_valid,
	output logic l_sop,
	output logic l_eop,
	output mrd_pkg::cplx_wide_t bin
);

	import mrd_pkg::*;

	// rotation index, term and running sums
	logic [1:0] k;
	cplx_wide_t term;
	logic signed [WIDE_W-1:0] acc_re;
	logic signed [WIDE_W-1:0] acc_im;

	// multiply by (-j)^k, with sign extension to the wide format
	function automatic cplx_wide_t rotate(input cplx_t x, input logic [1:0] k_in);
		cplx_wide_t r;
		logic signed [WIDE_W-1:0] xr;
		logic signed [WIDE_W-1:0] xi;
		xr = WIDE_W'(x.re);
		xi = WIDE_W'(x.im);
		case (k_in)
			2'd0:
			begin
				r.re = xr;
				r.im = xi;
			end
			// -j * (a + jb) = b - ja
			2'd1:
			begin
				r.re = xi;
				r.im = -xr;
			end
			2'd2:
			begin
				r.re = -xr;
				r.im = -xi;
			end
			// +j * (a + jb) = -b + ja
			default:
			begin
				r.re = -xi;
				r.im = xr;
			end
		endcase
		return r;
	endfunction

	// sum over the four samples; inverse turns -j into +j
	always_comb
	begin
		acc_re = '0;
		acc_im = '0;
		k = '0;
		term = '0;
		for (int n = 0; n < LANES; n++)
		begin
			k = 2'((n * BIN) % LANES);
			if (s_beat.inverse)
				k = 2'd0 - k;
			term = rotate(s_beat.samp[n], k);
			acc_re = acc_re + term.re;
			acc_im = acc_im + term.im;
		end
	end

	// control bits of the lane register
	always_ff @(posedge clk)
	begin
		if (reset)
			l_valid <= 1'b0;
		else if (advance)
			l_valid <= s_valid;
	end

	// bin payload along with its frame markers
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			bin.re <= acc_re;
			bin.im <= acc_im;
			l_sop <= s_beat.sop;
			l_eop <= s_beat.eop;
		end
	end

endmodule

/* verilog/mrd_dft4_top.sv */
// streaming 4-point dft top

`timescale 1ns/1ps

module mrd_dft4_top (
	input  logic clk,
	input  logic reset,
	input  logic sink_valid,
	output logic sink_ready,
	input  logic sink_sop,
	input  logic sink_eop,
	input  mrd_pkg::cplx_t [mrd_pkg::LANES-1:0] sink_data,
	input  logic inverse,
	input  logic source_ready,
	output logic source_valid,
	output mrd_pkg::source_beat_t source_beat
);

	import mrd_pkg::*;

	// shared pipeline enable from the source stage
	logic advance;

	// sink register
	logic s_valid;
	sink_beat_t s_beat;

	// lane registers, control taken from lane 0
	logic lane_valid [LANES];
	logic lane_sop [LANES];
	logic lane_eop [LANES];
	cplx_wide_t lane_bin [LANES];

	// packed beat seen by the source stage
	logic l_valid;
	lane_beat_t l_beat;

	assign sink_ready = advance;

	mrd_sink_stage sink0 (
		.clk        (clk),
		.reset      (reset),
		.advance    (advance),
		.sink_valid (sink_valid),
		.sink_sop   (sink_sop),
		.sink_eop   (sink_eop),
		.sink_data  (sink_data),
		.inverse    (inverse),
		.s_valid    (s_valid),
		.s_beat     (s_beat)
	);

	// one lane per output bin
	genvar b;
	generate
		for (b = 0; b < LANES; b++)
		begin : g_lane
			mrd_bin_lane #(
				.BIN (b)
			) lane (
				.clk     (clk),
				.reset   (reset),
				.advance (advance),
				.s_valid (s_valid),
				.s_beat  (s_beat),
				.l_valid (lane_valid[b]),
				.l_sop   (lane_sop[b]),
				.l_eop   (lane_eop[b]),
				.bin     (lane_bin[b])
			);

			assign l_beat.bin[b] = lane_bin[b];
		end
	endgenerate

	assign l_valid = lane_valid[0];
	assign l_beat.sop = lane_sop[0];
	assign l_beat.eop = lane_eop[0];

	mrd_bfp_source source0 (
		.clk          (clk),
		.reset        (reset),
		.l_valid      (l_valid),
		.l_beat       (l_beat),
		.source_ready (source_ready),
		.advance      (advance),
		.source_valid (source_valid),
		.source_beat  (source_beat)
	);

endmodule

/* verilog/mrd_pkg.sv */
// mrd dft4 shared types

package mrd_pkg;

	// sample and bin widths
	localparam int DATA_W = 18;
	localparam int LANES = 4;

	// two growth bits cover a sum of four samples
	localparam int WIDE_W = DATA_W + 2;

	// block exponent on the source side
	localparam int EXP_W = 4;

	// one complex input sample
	typedef struct packed {
		logic signed [DATA_W-1:0] re;
		logic signed [DATA_W-1:0] im;
	} cplx_t;

	// one complex bin before normalization
	typedef struct packed {
		logic signed [WIDE_W-1:0] re;
		logic signed [WIDE_W-1:0] im;
	} cplx_wide_t;

	// beat held in the sink register
	typedef struct packed {
		cplx_t [LANES-1:0] samp;
		logic sop;
		logic eop;
		logic inverse;
	} sink_beat_t;

	// beat after the bin lanes, still at full width
	typedef struct packed {
		cplx_wide_t [LANES-1:0] bin;
		logic sop;
		logic eop;
	} lane_beat_t;

	// normalized beat on the source port
	typedef struct packed {
		cplx_t [LANES-1:0] bin;
		logic sop;
		logic eop;
		logic [EXP_W-1:0] exp;
	} source_beat_t;

endpackage

/* verilog/mrd_sink_stage.sv */
// dft4 sink stage

`timescale 1ns/1ps

module mrd_sink_stage (
	input  logic clk,
	input  logic reset,
	input  logic advance,
	input  logic sink_valid,
	input  logic sink_sop,
	input  logic sink_eop,
	input  mrd_pkg::cplx_t [mrd_pkg::LANES-1:0] sink_data,
	input  logic inverse,
	output logic s_valid,
	output mrd_pkg::sink_beat_t s_beat
);

	import mrd_pkg::*;

	// frame tracking
	logic in_frame;
	logic inv_latched;

	// beat handed over this cycle
	logic accept;

	// beat is part of a frame, either opening it or inside it
	logic belongs;

	// inverse flag seen by the current beat
	logic beat_inverse;

	assign accept = advance & sink_valid;
	assign belongs = sink_sop | in_frame;

	// sop takes the live input, later beats the captured value
	assign beat_inverse = sink_sop ? inverse : inv_latched;

	// frame flag and inverse capture
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			in_frame <= 1'b0;
			inv_latched <= 1'b0;
		end
		else if (accept)
		begin
			if (sink_sop)
			begin
				// a sop inside a frame simply restarts it
				inv_latched <= inverse;
				in_frame <= ~sink_eop;
			end
			else if (in_frame && sink_eop)
			begin
				in_frame <= 1'b0;
			end
		end
	end

	// valid bit, dropped for stray beats outside a frame
	always_ff @(posedge clk)
	begin
		if (reset)
			s_valid <= 1'b0;
		else if (advance)
			s_valid <= sink_valid & belongs;
	end

	// payload register
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			s_beat.samp <= sink_data;
			s_beat.sop <= sink_sop;
			s_beat.eop <= sink_eop;
			s_beat.inverse <= beat_inverse;
		end
	end

endmodule
